/* Makefile */
TOP = arcade_io_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): src.f *.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f

run: obj_dir/V$(TOP)
	obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir sim.log

/* arcade_io_patterns.txt */
# K code pressed ctrl | J joy0 joy1 rotate ctrl | ctrl = {coin,start2,start1,left,right,fire,bomb}
# V pixel{r,g,b} flags{hs,vs,hbg,hfg,vb} level r g b sync{vga_hs,vga_vs} | A sample, all hex
# Pixel on blank V lines is replaced by a random value
J 00 00 1 00
K 6b 1 08
K 6b 0 00
K 74 1 04
K 74 0 00
K 76 1 40
K 76 0 00
K 05 1 10
K 06 1 30
K 05 0 20
K 06 0 00
K 29 1 02
K 29 0 00
K 11 1 01
K 11 0 00
K 75 1 00
J 00 00 0 04
K 72 1 0c
K 75 0 08
K 72 0 00
K 3c 1 00
K 00 0 00
J 04 00 0 08
J 00 08 0 04
J 03 00 0 00
J 03 00 1 0c
J 0c 00 1 00
J 10 00 1 02
J 00 20 1 01
J 30 30 0 03
K 29 1 03
J 00 00 0 02
K 29 0 00
V 1b 00 0 15 2a 3f 3
V 1b 00 3 15 2a 3f 3
V 00 01 0 00 00 00 3
V 1b 04 0 15 2a 3f 3
V 1b 02 0 15 2a 3f 3
V 00 06 0 00 00 00 3
V 3f 08 0 3f 3f 3f 2
V 3f 10 1 3f 3f 3f 1
V 3f 00 1 30 30 30 3
V 3f 00 3 10 10 10 3
V 1b 00 2 0b 15 20 3
V 1b 00 3 06 0b 10 3
V 1b 00 0 15 2a 3f 3
V 00 07 3 00 00 00 3
V 1b 10 3 06 0b 10 1
V 1b 00 3 15 2a 3f 3
V 1b 10 2 15 2a 3f 1
V 1b 10 2 0b 15 20 1
V 1b 00 2 0b 15 20 3
A 000
A 001
A 800
A fff

/* arcade_io_sva.sv */
// Concurrent checks on the arcade I/O top level, attached to every instance by bind
`timescale 1ns/1ps
`default_nettype none

module arcade_io_sva (
	input logic                            clk_22,
	input logic                            rst_n,
	input logic                            hblank_bg,
	input logic                            hblank_fg,
	input logic                            vblank,
	input logic                            btn_coin,
	input logic [1:0]                      btn_start,
	input logic                            m_left,
	input logic                            m_right,
	input logic                            m_fire,
	input logic                            m_bomb,
	input logic [arcade_pkg::vga_bits-1:0] vga_r,
	input logic [arcade_pkg::vga_bits-1:0] vga_g,
	input logic [arcade_pkg::vga_bits-1:0] vga_b,
	input logic                            audio_l,
	input logic                            audio_r
);

	// Mono stream on both channels
	a_audio_same: assert property (@(posedge clk_22) disable iff (!rst_n)
		audio_l == audio_r)
		else $error("audio_r differs from audio_l");

	a_ctrl_reset: assert property (@(posedge clk_22)
		!rst_n |=> (!btn_coin && btn_start == 2'b00 && !m_left && !m_right && !m_fire && !m_bomb))
		else $error("control outputs not cleared by reset");

	// Blank pixel reaches the pins as black one cycle later
	a_blank_zero: assert property (@(posedge clk_22) disable iff (!rst_n)
		((hblank_bg && hblank_fg) || vblank) |=> (vga_r == '0 && vga_g == '0 && vga_b == '0))
		else $error("colour not zero after a blank input");

endmodule

bind arcade_io_top arcade_io_sva u_sva (
	.clk_22(clk_22), .rst_n(rst_n),
	.hblank_bg(hblank_bg), .hblank_fg(hblank_fg), .vblank(vblank),
	.btn_coin(btn_coin), .btn_start(btn_start),
	.m_left(m_left), .m_right(m_right), .m_fire(m_fire), .m_bomb(m_bomb),
	.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
	.audio_l(audio_l), .audio_r(audio_r)
);

`default_nettype wire

/* arcade_io_tb.sv */
// Testbench for the arcade I/O glue, reads arcade_io_patterns.txt and checks every DUT result
`timescale 1ns/1ps
`default_nettype none

module arcade_io_tb;

	import arcade_pkg::*;

	localparam int dac_bits        = 12;
	localparam int cycles_per_line = 4100;   // Longest line is an audio window

	logic                  clk_22;
	logic                  rst_n;
	logic                  key_strobe;
	logic [7:0]            key_code;
	logic                  key_pressed;
	logic [7:0]            joystick_0;
	logic [7:0]            joystick_1;
	logic                  rotate;
	logic [1:0]            scanlines;
	logic [color_bits-1:0] r;
	logic [color_bits-1:0] g;
	logic [color_bits-1:0] b;
	logic                  hs;
	logic                  vs;
	logic                  hblank_bg;
	logic                  hblank_fg;
	logic                  vblank;
	logic [audio_bits-1:0] audio;
	logic                  btn_coin;
	logic [1:0]            btn_start;
	logic                  m_left;
	logic                  m_right;
	logic                  m_fire;
	logic                  m_bomb;
	logic [vga_bits-1:0]   vga_r;
	logic [vga_bits-1:0]   vga_g;
	logic [vga_bits-1:0]   vga_b;
	logic                  vga_hs;
	logic                  vga_vs;
	logic                  audio_l;
	logic                  audio_r;

	string       lines[$];
	int unsigned cycle_count = 0;
	int unsigned cycle_limit = 32'hffff_ffff;   // Set once the pattern file is loaded
	logic [6:0]  prev_ctrl;                     // {coin, start[1:0], left, right, fire, bomb}

	arcade_io_top #(.dac_bits(dac_bits)) u_dut (.*);

	initial clk_22 = 1'b0;
	always #5 clk_22 = ~clk_22;

	always @(posedge clk_22) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
			$display("TEST FAILED");
			$fatal(1, "simulation timed out");
		end
	end

	// ------------------------------------------------------------------
	// Failure reporting and compare tasks
	// ------------------------------------------------------------------
	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("** Error: %s expected 0x%0h, got 0x%0h at %0t", name, expected, actual, $time);
		$display("TEST FAILED");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic stop_run(input string reason);
		$display("Error: %s", reason);
		$display("TEST FAILED");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_controls(input logic [6:0] expected);
		if (btn_coin !== expected[6])
			report_mismatch("btn_coin", 32'(expected[6]), 32'(btn_coin));
		if (btn_start !== expected[5:4])
			report_mismatch("btn_start", 32'(expected[5:4]), 32'(btn_start));
		if (m_left !== expected[3])
			report_mismatch("m_left", 32'(expected[3]), 32'(m_left));
		if (m_right !== expected[2])
			report_mismatch("m_right", 32'(expected[2]), 32'(m_right));
		if (m_fire !== expected[1])
			report_mismatch("m_fire", 32'(expected[1]), 32'(m_fire));
		if (m_bomb !== expected[0])
			report_mismatch("m_bomb", 32'(expected[0]), 32'(m_bomb));
	endtask

	task automatic check_vga(input logic [vga_bits-1:0] exp_r, input logic [vga_bits-1:0] exp_g,
			input logic [vga_bits-1:0] exp_b, input logic [1:0] exp_sync);
		if (vga_r !== exp_r)
			report_mismatch("vga_r", 32'(exp_r), 32'(vga_r));
		if (vga_g !== exp_g)
			report_mismatch("vga_g", 32'(exp_g), 32'(vga_g));
		if (vga_b !== exp_b)
			report_mismatch("vga_b", 32'(exp_b), 32'(vga_b));
		if (vga_hs !== exp_sync[1])
			report_mismatch("vga_hs", 32'(exp_sync[1]), 32'(vga_hs));
		if (vga_vs !== exp_sync[0])
			report_mismatch("vga_vs", 32'(exp_sync[0]), 32'(vga_vs));
	endtask

	task automatic check_audio_count(input string name, input int expected, input int actual);
		if (actual != expected)
			report_mismatch(name, 32'(expected), 32'(actual));
	endtask

	task automatic check_audio_level(input logic expected);
		if (audio_l !== expected)
			report_mismatch("audio_l", 32'(expected), 32'(audio_l));
		if (audio_r !== expected)
			report_mismatch("audio_r", 32'(expected), 32'(audio_r));
	endtask

	task automatic check_reset_state();
		check_controls(7'h00);
		check_vga('0, '0, '0, 2'b11);   // Syncs idle high
		check_audio_level(1'b0);
	endtask

	// ------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------
	// Called on a falling edge, leaves rst_n low after 8 rising edges for the caller to release
	task automatic hold_reset(input logic [audio_bits-1:0] sample);
		rst_n       = 1'b0;
		key_strobe  = 1'b0;
		key_code    = 8'h00;
		key_pressed = 1'b0;
		joystick_0  = 8'h00;
		joystick_1  = 8'h00;
		{r, g, b}   = '0;
		{hs, vs, hblank_bg, hblank_fg, vblank} = 5'b0;
		audio       = sample;
		repeat (8) @(negedge clk_22);
	endtask

	task automatic load_patterns();
		int    fd;
		int    n;
		string line;
		fd = $fopen("arcade_io_patterns.txt", "r");
		if (fd == 0)
			stop_run("could not open arcade_io_patterns.txt");
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && (line[0] == "K" || line[0] == "J" || line[0] == "V" || line[0] == "A"))
				lines.push_back(line);
		end
		$fclose(fd);
	endtask

	task automatic run_key(input string line);
		logic [31:0] code;
		logic [31:0] pressed;
		logic [31:0] expected;
		int          n;
		n = $sscanf(line, "K %h %h %h", code, pressed, expected);
		if (n != 3)
			stop_run({"malformed key line: ", line});
		@(negedge clk_22);
		key_strobe  = 1'b1;
		key_code    = code[7:0];
		key_pressed = pressed[0];
		@(negedge clk_22);
		key_strobe = 1'b0;
		check_controls(prev_ctrl);   // Only the latch has moved
		@(negedge clk_22);
		check_controls(expected[6:0]);
		prev_ctrl = expected[6:0];
	endtask

	task automatic run_joystick(input string line);
		logic [31:0] js0;
		logic [31:0] js1;
		logic [31:0] rot;
		logic [31:0] expected;
		int          n;
		n = $sscanf(line, "J %h %h %h %h", js0, js1, rot, expected);
		if (n != 4)
			stop_run({"malformed joystick line: ", line});
		@(negedge clk_22);
		joystick_0 = js0[7:0];
		joystick_1 = js1[7:0];
		rotate     = rot[0];
		@(negedge clk_22);
		check_controls(expected[6:0]);
		prev_ctrl = expected[6:0];
	endtask

	task automatic run_video(input string line);
		logic [31:0] pixel;
		logic [31:0] flags;
		logic [31:0] level;
		logic [31:0] exp_r;
		logic [31:0] exp_g;
		logic [31:0] exp_b;
		logic [31:0] exp_sync;
		logic [31:0] fill;
		int          n;
		n = $sscanf(line, "V %h %h %h %h %h %h %h",
			pixel, flags, level, exp_r, exp_g, exp_b, exp_sync);
		if (n != 7)
			stop_run({"malformed video line: ", line});
		if ((flags[2] & flags[1]) | flags[0]) begin
			fill  = $urandom();
			pixel = {26'b0, fill[5:0]};   // Any colour as blanking hides it
		end
		@(negedge clk_22);
		{r, g, b} = pixel[5:0];
		{hs, vs, hblank_bg, hblank_fg, vblank} = flags[4:0];
		scanlines = level[1:0];
		@(negedge clk_22);
		check_vga(exp_r[vga_bits-1:0], exp_g[vga_bits-1:0], exp_b[vga_bits-1:0], exp_sync[1:0]);
	endtask

	task automatic run_audio(input string line);
		logic [31:0] sample;
		int          n;
		int          ones_l;
		int          ones_r;
		int          expected;
		n = $sscanf(line, "A %h", sample);
		if (n != 1)
			stop_run({"malformed audio line: ", line});
		hold_reset(sample[audio_bits-1:0]);
		rst_n  = 1'b1;
		ones_l = 0;
		ones_r = 0;
		repeat (1 << dac_bits) begin
			@(negedge clk_22);
			ones_l += audio_l ? 1 : 0;
			ones_r += audio_r ? 1 : 0;
		end
		expected = int'(sample[audio_bits-1:0]) << (dac_bits - audio_bits);
		check_audio_count("audio_l ones", expected, ones_l);
		check_audio_count("audio_r ones", expected, ones_r);
		prev_ctrl = 7'h00;   // Keys cleared and sticks idle
	endtask

	initial begin
		logic [7:0] kind;
		void'($urandom(11317));
		rst_n       = 1'b0;
		key_strobe  = 1'b0;
		key_code    = 8'h00;
		key_pressed = 1'b0;
		joystick_0  = 8'h00;
		joystick_1  = 8'h00;
		rotate      = 1'b0;
		scanlines   = 2'b00;
		{r, g, b}   = '0;
		{hs, vs, hblank_bg, hblank_fg, vblank} = 5'b0;
		audio       = '0;
		load_patterns();
		if (lines.size() == 0)
			stop_run("the pattern file holds no pattern lines");
		cycle_limit = lines.size() * cycles_per_line + 100;
		hold_reset('0);
		check_reset_state();
		rst_n = 1'b1;
		@(negedge clk_22);
		check_reset_state();
		prev_ctrl = 7'h00;
		foreach (lines[i]) begin
			kind = lines[i][0];
			case (kind)
				"K": run_key(lines[i]);
				"J": run_joystick(lines[i]);
				"V": run_video(lines[i]);
				default: run_audio(lines[i]);
			endcase
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* arcade_io_top.sv */
// Top level of the arcade board glue, joining control, video and audio paths on one clock
`timescale 1ns/1ps
`default_nettype none

module arcade_io_top #(
	parameter int dac_bits = 15   // Modulator width, not below the sample width
) (
	input  logic                             clk_22,
	input  logic                             rst_n,
	// Keyboard events and joysticks
	input  logic                             key_strobe,
	input  logic [7:0]                       key_code,
	input  logic                             key_pressed,
	input  logic [7:0]                       joystick_0,
	input  logic [7:0]                       joystick_1,
	// Option levels
	input  logic                             rotate,
	input  logic [1:0]                       scanlines,
	// Video from the core
	input  logic [arcade_pkg::color_bits-1:0] r,
	input  logic [arcade_pkg::color_bits-1:0] g,
	input  logic [arcade_pkg::color_bits-1:0] b,
	input  logic                             hs,
	input  logic                             vs,
	input  logic                             hblank_bg,
	input  logic                             hblank_fg,
	input  logic                             vblank,
	input  logic [arcade_pkg::audio_bits-1:0] audio,
	// Game controls
	output logic                             btn_coin,
	output logic [1:0]                       btn_start,
	output logic                             m_left,
	output logic                             m_right,
	output logic                             m_fire,
	output logic                             m_bomb,
	// Board outputs
	output logic [arcade_pkg::vga_bits-1:0]   vga_r,
	output logic [arcade_pkg::vga_bits-1:0]   vga_g,
	output logic [arcade_pkg::vga_bits-1:0]   vga_b,
	output logic                             vga_hs,
	output logic                             vga_vs,
	output logic                             audio_l,
	output logic                             audio_r
);

	logic kb_up, kb_down, kb_left, kb_right;
	logic kb_coin, kb_start1, kb_start2, kb_fire, kb_bomb;

	// --------------------------------------------------------------------
	// Control pipeline, latch then map
	// --------------------------------------------------------------------
	key_latch u_key_latch (
		.clk_22(clk_22), .rst_n(rst_n),
		.key_strobe(key_strobe), .key_code(key_code), .key_pressed(key_pressed),
		.kb_up(kb_up), .kb_down(kb_down), .kb_left(kb_left), .kb_right(kb_right),
		.kb_coin(kb_coin), .kb_start1(kb_start1), .kb_start2(kb_start2),
		.kb_fire(kb_fire), .kb_bomb(kb_bomb)
	);

	control_mapper u_control_mapper (
		.clk_22(clk_22), .rst_n(rst_n),
		.kb_up(kb_up), .kb_down(kb_down), .kb_left(kb_left), .kb_right(kb_right),
		.kb_coin(kb_coin), .kb_start1(kb_start1), .kb_start2(kb_start2),
		.kb_fire(kb_fire), .kb_bomb(kb_bomb),
		.joystick_0(joystick_0), .joystick_1(joystick_1), .rotate(rotate),
		.btn_coin(btn_coin), .btn_start(btn_start),
		.m_left(m_left), .m_right(m_right), .m_fire(m_fire), .m_bomb(m_bomb)
	);

	video_out u_video_out (
		.clk_22(clk_22), .rst_n(rst_n),
		.r(r), .g(g), .b(b), .hs(hs), .vs(vs),
		.hblank_bg(hblank_bg), .hblank_fg(hblank_fg), .vblank(vblank),
		.scanlines(scanlines),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs)
	);

	audio_dac #(.dac_bits(dac_bits)) u_audio_dac (
		.clk_22(clk_22), .rst_n(rst_n),
		.sample(audio),
		.dac_out(audio_l)
	);

	assign audio_r = audio_l;   // Mono core, same stream on both channels

endmodule

`default_nettype wire

/* arcade_pkg.sv */
// Shared widths, keyboard scan codes and joystick bit positions, imported by the arcade I/O RTL
`default_nettype none

package arcade_pkg;

	// --------------------------------------------------------------------
	// Data widths
	// --------------------------------------------------------------------
	localparam int color_bits = 2;    // Core colour per channel
	localparam int vga_bits   = 6;    // VGA colour per channel
	localparam int audio_bits = 12;   // Audio sample from the core

	// --------------------------------------------------------------------
	// PS/2 set 2 scan codes, make codes only
	// --------------------------------------------------------------------
	localparam logic [7:0] code_up     = 8'h75;   // Keypad 8 / up arrow
	localparam logic [7:0] code_down   = 8'h72;   // Keypad 2 / down arrow
	localparam logic [7:0] code_left   = 8'h6b;   // Keypad 4 / left arrow
	localparam logic [7:0] code_right  = 8'h74;   // Keypad 6 / right arrow
	localparam logic [7:0] code_coin   = 8'h76;   // ESC
	localparam logic [7:0] code_start1 = 8'h05;   // F1
	localparam logic [7:0] code_start2 = 8'h06;   // F2
	localparam logic [7:0] code_fire   = 8'h29;   // Space
	localparam logic [7:0] code_bomb   = 8'h11;   // Alt

	// --------------------------------------------------------------------
	// Joystick word bit positions
	// --------------------------------------------------------------------
	// Same layout for both joystick words from the host controller
	localparam int joy_right = 0;
	localparam int joy_left  = 1;
	localparam int joy_down  = 2;
	localparam int joy_up    = 3;
	localparam int joy_fire  = 4;   // Main fire button
	localparam int joy_bomb  = 5;   // Second button, barrier / bomb

endpackage

`default_nettype wire

/* audio_dac.sv */
// First-order sigma-delta modulator turning an audio sample into a one-bit stream for an RC filter
`timescale 1ns/1ps
`default_nettype none

module audio_dac #(
	parameter int dac_bits
) (
	input  logic                             clk_22,
	input  logic                             rst_n,
	input  logic [arcade_pkg::audio_bits-1:0] sample,
	output logic                             dac_out
);

	import arcade_pkg::*;

	localparam int pad = dac_bits - audio_bits;   // Zero bits on the right

	logic [dac_bits-1:0] padded;
	logic [dac_bits-1:0] acc;
	logic [dac_bits:0]   sum;

	// Sample sits in the upper bits of the accumulator width
	assign padded = dac_bits'(sample) << pad;
	assign sum    = {1'b0, acc} + {1'b0, padded};

	// --------------------------------------------------------------------
	// Accumulator
	// --------------------------------------------------------------------
	// Carry out gives the pulse density, the remainder carries the error
	always_ff @(posedge clk_22) begin
		if (!rst_n) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= sum[dac_bits-1:0];
			dac_out <= sum[dac_bits];   // One per overflow
		end
	end

endmodule

`default_nettype wire

/* control_mapper.sv */
// Second control stage, merges keyboard buttons and both joysticks into registered game controls
`timescale 1ns/1ps
`default_nettype none

module control_mapper (
	input  logic       clk_22,
	input  logic       rst_n,
	input  logic       kb_up,
	input  logic       kb_down,
	input  logic       kb_left,
	input  logic       kb_right,
	input  logic       kb_coin,
	input  logic       kb_start1,
	input  logic       kb_start2,
	input  logic       kb_fire,
	input  logic       kb_bomb,
	input  logic [7:0] joystick_0,
	input  logic [7:0] joystick_1,
	input  logic       rotate,       // 0 selects the rotated cabinet mapping
	output logic       btn_coin,
	output logic [1:0] btn_start,    // {player 2, player 1}
	output logic       m_left,
	output logic       m_right,
	output logic       m_fire,
	output logic       m_bomb
);

	import arcade_pkg::*;

	logic any_up, any_down, any_left, any_right;
	logic left_next, right_next;

	// Direction OR of keyboard and both sticks
	assign any_up    = kb_up    | joystick_0[joy_up]    | joystick_1[joy_up];
	assign any_down  = kb_down  | joystick_0[joy_down]  | joystick_1[joy_down];
	assign any_left  = kb_left  | joystick_0[joy_left]  | joystick_1[joy_left];
	assign any_right = kb_right | joystick_0[joy_right] | joystick_1[joy_right];

	// Rotated screen uses the vertical axis for horizontal movement
	assign left_next  = rotate ? any_left  : any_down;
	assign right_next = rotate ? any_right : any_up;

	// --------------------------------------------------------------------
	// Output register
	// --------------------------------------------------------------------
	always_ff @(posedge clk_22) begin
		if (!rst_n) begin
			btn_coin  <= 1'b0;
			btn_start <= 2'b00;
			m_left    <= 1'b0;
			m_right   <= 1'b0;
			m_fire    <= 1'b0;
			m_bomb    <= 1'b0;
		end else begin
			btn_coin  <= kb_coin;                  // Keyboard only
			btn_start <= {kb_start2, kb_start1};
			m_left    <= left_next;
			m_right   <= right_next;
			m_fire    <= kb_fire | joystick_0[joy_fire] | joystick_1[joy_fire];
			m_bomb    <= kb_bomb | joystick_0[joy_bomb] | joystick_1[joy_bomb];
		end
	end

endmodule

`default_nettype wire

/* key_latch.sv */
// Keyboard event latch that turns scan-code strobes into held button levels for the mapper
`timescale 1ns/1ps
`default_nettype none

module key_latch (
	input  logic       clk_22,
	input  logic       rst_n,
	input  logic       key_strobe,    // One-cycle event pulse
	input  logic [7:0] key_code,
	input  logic       key_pressed,   // 1 make, 0 break
	output logic       kb_up,
	output logic       kb_down,
	output logic       kb_left,
	output logic       kb_right,
	output logic       kb_coin,
	output logic       kb_start1,
	output logic       kb_start2,
	output logic       kb_fire,
	output logic       kb_bomb
);

	import arcade_pkg::*;

	// --------------------------------------------------------------------
	// Button flops
	// --------------------------------------------------------------------
	// Each flop holds its level until the next event with the same code
	always_ff @(posedge clk_22) begin
		if (!rst_n) begin
			kb_up     <= 1'b0;
			kb_down   <= 1'b0;
			kb_left   <= 1'b0;
			kb_right  <= 1'b0;
			kb_coin   <= 1'b0;
			kb_start1 <= 1'b0;
			kb_start2 <= 1'b0;
			kb_fire   <= 1'b0;
			kb_bomb   <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				code_up:     kb_up     <= key_pressed;
				code_down:   kb_down   <= key_pressed;
				code_left:   kb_left   <= key_pressed;
				code_right:  kb_right  <= key_pressed;
				code_coin:   kb_coin   <= key_pressed;
				code_start1: kb_start1 <= key_pressed;
				code_start2: kb_start2 <= key_pressed;
				code_fire:   kb_fire   <= key_pressed;
				code_bomb:   kb_bomb   <= key_pressed;
				default: begin
					// Unknown code, all levels hold
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* src.f */
arcade_pkg.sv
key_latch.sv
control_mapper.sv
video_out.sv
audio_dac.sv
arcade_io_top.sv
arcade_io_sva.sv
arcade_io_tb.sv

/* video_out.sv */
// Registered VGA output stage with blanking, colour widening, scanline darkening and sync inversion
`timescale 1ns/1ps
`default_nettype none

module video_out (
	input  logic                           clk_22,
	input  logic                           rst_n,
	input  logic [arcade_pkg::color_bits-1:0] r,
	input  logic [arcade_pkg::color_bits-1:0] g,
	input  logic [arcade_pkg::color_bits-1:0] b,
	input  logic                           hs,          // Active high from the core
	input  logic                           vs,
	input  logic                           hblank_bg,
	input  logic                           hblank_fg,
	input  logic                           vblank,
	input  logic [1:0]                     scanlines,   // 0 off, 1..3 in quarters
	output logic [arcade_pkg::vga_bits-1:0]   vga_r,
	output logic [arcade_pkg::vga_bits-1:0]   vga_g,
	output logic [arcade_pkg::vga_bits-1:0]   vga_b,
	output logic                           vga_hs,      // Active low
	output logic                           vga_vs
);

	import arcade_pkg::*;

	localparam int rep = vga_bits / color_bits;   // Copies per widened value

	logic hs_d;
	logic hs_rise;
	logic line_odd;
	logic blank;

	// Widen by repetition, then take level quarters off on odd lines
	function automatic logic [vga_bits-1:0] shade(
		input logic [color_bits-1:0] c,
		input logic [1:0]            level,
		input logic                  odd
	);
		logic [vga_bits-1:0] v;
		logic [vga_bits+1:0] prod;
		v    = {rep{c}};
		prod = v * level;   // At most 63 * 3, fits in 8 bits
		if (odd)
			return v - prod[vga_bits+1:2];
		return v;
	endfunction

	assign hs_rise = hs & ~hs_d;
	assign blank   = (hblank_bg & hblank_fg) | vblank;   // Both h flags needed

	// --------------------------------------------------------------------
	// Line parity and output register
	// --------------------------------------------------------------------
	always_ff @(posedge clk_22) begin
		if (!rst_n) begin
			hs_d     <= 1'b0;
			line_odd <= 1'b0;
			vga_r    <= '0;
			vga_g    <= '0;
			vga_b    <= '0;
			vga_hs   <= 1'b1;   // Inactive
			vga_vs   <= 1'b1;
		end else begin
			hs_d <= hs;
			if (hs_rise)
				line_odd <= ~line_odd;
			vga_r  <= blank ? '0 : shade(r, scanlines, line_odd);
			vga_g  <= blank ? '0 : shade(g, scanlines, line_odd);
			vga_b  <= blank ? '0 : shade(b, scanlines, line_odd);
			vga_hs <= ~hs;
			vga_vs <= ~vs;
		end
	end

endmodule

`default_nettype wire
